// ==== rtl/router_consts.svh ====
//----------------------------------------------------------
// router constants
// port count, header layout, host bus widths, identity
// word and the host register map
//----------------------------------------------------------
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// ports and header
`define ROUTER_NUM_PORTS    16
`define ROUTER_PORT_W       4
`define ROUTER_PAD_CYCLES   4

// host bus
`define ROUTER_WB_ADR_W     16
`define ROUTER_WB_DAT_W     16

// register map, all words read only
`define ROUTER_CHIP_ID      16'h5a03
`define ROUTER_ID_ADDR      16'h0000
`define ROUTER_CNT_IN_BASE  16'h2000
`define ROUTER_CNT_OUT_BASE 16'h2010

`endif

// ==== rtl/router_pkg.sv ====
//----------------------------------------------------------
// router types
// port vectors and matrices, lane bundle, wishbone request
// and response, decoder and arbiter states
//----------------------------------------------------------
`include "router_consts.svh"

package router_pkg;

  typedef logic [`ROUTER_NUM_PORTS-1:0] port_vec_t;
  typedef logic [`ROUTER_PORT_W-1:0]    port_id_t;
  typedef logic [`ROUTER_WB_ADR_W-1:0]  wb_adr_t;
  typedef logic [`ROUTER_WB_DAT_W-1:0]  wb_dat_t;

  // one row per port, request rows by input and grant rows by output
  typedef port_vec_t [`ROUTER_NUM_PORTS-1:0] port_mat_t;

  // serial lanes of all ports, active low
  typedef struct packed {
    port_vec_t frame_n;
    port_vec_t valid_n;
    port_vec_t din;
  } lanes_t;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

  typedef struct packed {
    wb_dat_t dat;
    logic    ack;
  } wb_rsp_t;

  typedef enum logic [2:0] {DEC_ADDR, DEC_PAD, DEC_REQ, DEC_WAIT, DEC_FWD} dec_state_e;
  typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT, ARB_BUSY} arb_state_e;

endpackage

// ==== rtl/router_header_decoder.sv ====
//----------------------------------------------------------
// router header decoder
// collects the destination address of one input port,
// checks the padding, requests the destination output and
// holds busy_n low until the arbiter grants it
//----------------------------------------------------------
`timescale 1ns/100ps
`include "router_consts.svh"

module router_header_decoder
  import router_pkg::*;
#(
  parameter int port_num = 0
) (
  input  logic      io,
  input  logic      arst_n,
  input  lanes_t    rx,
  input  port_vec_t grant_col,
  output port_vec_t request,
  output logic      busy_n
);

  localparam int cnt_w = $clog2(`ROUTER_PORT_W);
  localparam logic [cnt_w-1:0] addr_last = cnt_w'(`ROUTER_PORT_W - 1);
  // the last two pad cycles are spent in DEC_REQ and DEC_WAIT
  localparam logic [cnt_w-1:0] pad_last = cnt_w'(`ROUTER_PAD_CYCLES - 3);

  dec_state_e       state_q, state_d;
  logic [cnt_w-1:0] cnt_q, cnt_d;
  port_id_t         dst_q, dst_d;
  logic             busy_n_d;
  logic             frame_n;
  logic             din;
  logic             pad_bad;

  assign frame_n = rx.frame_n[port_num];
  assign din     = rx.din[port_num];
  // padding must keep frame low and din high
  assign pad_bad = frame_n | ~din;

  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q;
    dst_d    = dst_q;
    request  = '0;
    busy_n_d = 1'b1;
    case (state_q)
      DEC_ADDR: begin
        if (frame_n) begin
          cnt_d = '0;
        end else begin
          // address arrives lsb first
          dst_d[cnt_q] = din;
          cnt_d        = cnt_q + 1'b1;
          if (cnt_q == addr_last) begin
            cnt_d   = '0;
            state_d = DEC_PAD;
          end
        end
      end
      DEC_PAD: begin
        cnt_d = cnt_q + 1'b1;
        if (pad_bad) begin
          cnt_d   = '0;
          state_d = DEC_ADDR;
        end else if (cnt_q == pad_last) begin
          cnt_d   = '0;
          state_d = DEC_REQ;
        end
      end
      DEC_REQ: begin
        if (pad_bad) begin
          state_d = DEC_ADDR;
        end else begin
          request[dst_q] = 1'b1;
          state_d        = DEC_WAIT;
        end
      end
      DEC_WAIT: begin
        if (pad_bad) begin
          state_d = DEC_ADDR;
        end else if (grant_col[dst_q]) begin
          state_d = DEC_FWD;
        end else begin
          // keep asking and stall the sender in padding
          request[dst_q] = 1'b1;
          busy_n_d       = 1'b0;
        end
      end
      DEC_FWD: begin
        if (frame_n) state_d = DEC_ADDR;
      end
      default: state_d = DEC_ADDR;
    endcase
  end

  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= DEC_ADDR;
      cnt_q   <= '0;
      busy_n  <= 1'b1;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      busy_n  <= busy_n_d;
    end
  end

  always_ff @(posedge io) begin
    dst_q <= dst_d;
  end

endmodule

// ==== rtl/router_output_arbiter.sv ====
//----------------------------------------------------------
// router output arbiter
// round-robin choice among the inputs requesting one output,
// a single-cycle grant to the winner and a hold on the
// source until its frame ends
//----------------------------------------------------------
`timescale 1ns/100ps
`include "router_consts.svh"

module router_output_arbiter
  import router_pkg::*;
#(
  parameter int port_num = 0
) (
  input  logic      io,
  input  logic      arst_n,
  input  port_vec_t request_col,
  input  logic      src_frame_n,
  output port_vec_t grant,
  output port_id_t  src,
  output logic      active
);

  localparam int num_ports = `ROUTER_NUM_PORTS;

  arb_state_e               state_q, state_d;
  port_id_t                 last_q;
  port_id_t                 src_q;
  port_id_t                 offset;
  port_id_t                 pick;
  logic [2*num_ports-1:0]   doubled;
  port_vec_t                rotated;
  logic                     hit;

  // rotate so that bit 0 is the input after the last one granted
  assign offset  = last_q + 1'b1;
  assign doubled = {request_col, request_col} >> offset;
  assign rotated = doubled[num_ports-1:0];

  // lowest set bit of the rotated column wins
  always_comb begin
    hit  = |rotated;
    pick = offset;
    for (int i = num_ports - 1; i >= 0; i--) begin
      if (rotated[i]) pick = offset + port_id_t'(i);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (hit) state_d = ARB_GRANT;
      end
      ARB_GRANT: state_d = ARB_BUSY;
      ARB_BUSY: begin
        // registered frame_n high marks the last payload bit
        if (src_frame_n) state_d = ARB_IDLE;
      end
      default: state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ARB_IDLE;
      last_q  <= '1;
      // idle source points at the own port
      src_q   <= port_id_t'(port_num);
    end else begin
      state_q <= state_d;
      if (state_q == ARB_IDLE && hit) begin
        last_q <= pick;
        src_q  <= pick;
      end
    end
  end

  always_comb begin
    grant = '0;
    if (state_q == ARB_GRANT) grant[src_q] = 1'b1;
  end

  assign src    = src_q;
  assign active = (state_q != ARB_IDLE);

endmodule

// ==== rtl/router_crossbar.sv ====
//----------------------------------------------------------
// router crossbar
// one register stage on all input lanes, then per output
// the lanes of the granted source, idle high otherwise
//----------------------------------------------------------
`timescale 1ns/100ps
`include "router_consts.svh"

module router_crossbar
  import router_pkg::*;
(
  input  logic                               io,
  input  lanes_t                             rx,
  input  port_id_t [`ROUTER_NUM_PORTS-1:0]   src,
  input  port_vec_t                          active,
  output port_vec_t                          src_frame_n,
  output lanes_t                             tx
);

  localparam int num_ports = `ROUTER_NUM_PORTS;

  lanes_t rx_q;

  always_ff @(posedge io) begin
    rx_q <= rx;
  end

  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      // arbiters watch the source frame even before it reaches tx
      src_frame_n[o] = rx_q.frame_n[src[o]];
      if (active[o]) begin
        tx.frame_n[o] = rx_q.frame_n[src[o]];
        tx.valid_n[o] = rx_q.valid_n[src[o]];
        tx.din[o]     = rx_q.din[src[o]];
      end else begin
        tx.frame_n[o] = 1'b1;
        tx.valid_n[o] = 1'b1;
        tx.din[o]     = 1'b1;
      end
    end
  end

endmodule

// ==== rtl/router_host_regs.sv ====
//----------------------------------------------------------
// router host registers
// wishbone classic slave with the chip identity word and
// one frame counter per input and per output port
//----------------------------------------------------------
`timescale 1ns/100ps
`include "router_consts.svh"

module router_host_regs
  import router_pkg::*;
(
  input  logic      io,
  input  logic      arst_n,
  input  wb_req_t   wb_req,
  output wb_rsp_t   wb_rsp,
  input  port_vec_t rx_frame_n,
  input  port_vec_t tx_frame_n
);

  localparam int      num_ports = `ROUTER_NUM_PORTS;
  localparam wb_adr_t in_base   = `ROUTER_CNT_IN_BASE;
  localparam wb_adr_t out_base  = `ROUTER_CNT_OUT_BASE;

  port_vec_t rx_prev_q, tx_prev_q;
  port_vec_t rx_done, tx_done;
  wb_dat_t   cnt_in  [num_ports];
  wb_dat_t   cnt_out [num_ports];
  wb_dat_t   rd_dat;
  wb_dat_t   dat_q;
  logic      ack_q;
  logic      acked_q;
  logic      ack_d;

  // a frame is complete on the rising edge of frame_n
  assign rx_done = ~rx_prev_q & rx_frame_n;
  assign tx_done = ~tx_prev_q & tx_frame_n;

  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      rx_prev_q <= '1;
      tx_prev_q <= '1;
      for (int i = 0; i < num_ports; i++) begin
        cnt_in[i]  <= '0;
        cnt_out[i] <= '0;
      end
    end else begin
      rx_prev_q <= rx_frame_n;
      tx_prev_q <= tx_frame_n;
      for (int i = 0; i < num_ports; i++) begin
        if (rx_done[i]) cnt_in[i] <= cnt_in[i] + 1'b1;
        if (tx_done[i]) cnt_out[i] <= cnt_out[i] + 1'b1;
      end
    end
  end

  // register map decode, unmapped words read as zero
  always_comb begin
    rd_dat = '0;
    if (wb_req.adr == `ROUTER_ID_ADDR) begin
      rd_dat = `ROUTER_CHIP_ID;
    end else if (wb_req.adr[`ROUTER_WB_ADR_W-1:`ROUTER_PORT_W] ==
                 in_base[`ROUTER_WB_ADR_W-1:`ROUTER_PORT_W]) begin
      rd_dat = cnt_in[wb_req.adr[`ROUTER_PORT_W-1:0]];
    end else if (wb_req.adr[`ROUTER_WB_ADR_W-1:`ROUTER_PORT_W] ==
                 out_base[`ROUTER_WB_ADR_W-1:`ROUTER_PORT_W]) begin
      rd_dat = cnt_out[wb_req.adr[`ROUTER_PORT_W-1:0]];
    end
  end

  // one ack per strobe, rearmed only after stb has dropped
  assign ack_d = wb_req.cyc & wb_req.stb & ~ack_q & ~acked_q;

  always_ff @(posedge io or negedge arst_n) begin
    if (!arst_n) begin
      ack_q   <= 1'b0;
      acked_q <= 1'b0;
    end else begin
      ack_q   <= ack_d;
      acked_q <= (acked_q | ack_q) & wb_req.stb;
    end
  end

  // writes are acknowledged but change nothing
  always_ff @(posedge io) begin
    if (ack_d && !wb_req.we) dat_q <= rd_dat;
  end

  assign wb_rsp.dat = dat_q;
  assign wb_rsp.ack = ack_q;

endmodule

// ==== rtl/router_top.sv ====
//----------------------------------------------------------
// router top level
// 16 header decoders and 16 output arbiters around one
// crossbar, plus the wishbone host register block
//----------------------------------------------------------
`timescale 1ns/100ps
`include "router_consts.svh"

module router_top
  import router_pkg::*;
(
  input  logic      io,
  input  logic      arst_n,
  input  lanes_t    rx,
  output lanes_t    tx,
  output port_vec_t busy_n,
  input  wb_req_t   wb_req,
  output wb_rsp_t   wb_rsp
);

  // request rows by input, grant rows by output
  port_mat_t                         req_row, req_col;
  port_mat_t                         gnt_row, gnt_col;
  port_id_t [`ROUTER_NUM_PORTS-1:0]  src;
  port_vec_t                         active;
  port_vec_t                         src_frame_n;

  for (genvar i = 0; i < `ROUTER_NUM_PORTS; i++) begin : g_xpose
    for (genvar j = 0; j < `ROUTER_NUM_PORTS; j++) begin : g_bit
      assign req_col[j][i] = req_row[i][j];
      assign gnt_col[i][j] = gnt_row[j][i];
    end
  end

  for (genvar p = 0; p < `ROUTER_NUM_PORTS; p++) begin : g_port
    router_header_decoder #(
      .port_num (p)
    ) dec_i (
      .io        (io),
      .arst_n    (arst_n),
      .rx        (rx),
      .grant_col (gnt_col[p]),
      .request   (req_row[p]),
      .busy_n    (busy_n[p])
    );

    router_output_arbiter #(
      .port_num (p)
    ) arb_i (
      .io          (io),
      .arst_n      (arst_n),
      .request_col (req_col[p]),
      .src_frame_n (src_frame_n[p]),
      .grant       (gnt_row[p]),
      .src         (src[p]),
      .active      (active[p])
    );
  end

  router_crossbar xbar_i (
    .io          (io),
    .rx          (rx),
    .src         (src),
    .active      (active),
    .src_frame_n (src_frame_n),
    .tx          (tx)
  );

  router_host_regs host_i (
    .io         (io),
    .arst_n     (arst_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .rx_frame_n (rx.frame_n),
    .tx_frame_n (tx.frame_n)
  );

endmodule

// ==== verif/router_tb.sv ====
//----------------------------------------------------------
// router testbench
// directed tests of the host map, single and parallel
// routes, contention, round-robin order and frame counters
//----------------------------------------------------------
`timescale 1ns/100ps
`include "router_consts.svh"

module router_tb
  import router_pkg::*;
();

  localparam int num_ports  = `ROUTER_NUM_PORTS;
  localparam int wait_limit = 2000;

  logic        io;
  logic        arst_n;
  lanes_t      rx;
  lanes_t      tx;
  port_vec_t   busy_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;

  integer      seed;
  int          errors;
  int          checks;
  int          tests;
  int          err_at_start;
  int          sent_cnt [num_ports];
  int          got_cnt  [num_ports];
  logic [63:0] mon_bits [num_ports];
  int          mon_len  [num_ports];
  logic [63:0] got_bits [num_ports][8];
  int          got_len  [num_ports][8];
  port_vec_t   prev_frame_n;
  port_vec_t   low_seen;
  port_vec_t   busy_seen;
  port_id_t    last7;

  router_top dut_i (
    .io     (io),
    .arst_n (arst_n),
    .rx     (rx),
    .tx     (tx),
    .busy_n (busy_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    io = 1'b0;
    forever #2 io = ~io;
  end

  // output monitors, sampled away from the driving edge
  always @(negedge io) begin
    if (arst_n) begin
      for (int o = 0; o < num_ports; o++) begin
        if (!tx.frame_n[o]) low_seen[o] = 1'b1;
        if (!tx.valid_n[o] && mon_len[o] < 64) begin
          mon_bits[o][mon_len[o]] = tx.din[o];
          mon_len[o]++;
        end
        // rising frame closes the packet
        if (tx.frame_n[o] && !prev_frame_n[o]) begin
          got_bits[o][got_cnt[o] % 8] = mon_bits[o];
          got_len[o][got_cnt[o] % 8]  = mon_len[o];
          got_cnt[o]++;
          mon_bits[o] = '0;
          mon_len[o]  = 0;
        end
      end
      prev_frame_n = tx.frame_n;
      busy_seen    = busy_seen | ~busy_n;
    end
  end

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $finish;
  endtask

  task automatic check_word(input string name, input wb_dat_t got, input wb_dat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bits(input string name, input logic [63:0] got, input int got_n,
                            input logic [63:0] exp, input int exp_n);
    logic [63:0] mask;
    mask = ~(64'hffff_ffff_ffff_ffff << exp_n);
    checks++;
    if (got_n != exp_n || (got & mask) !== (exp & mask)) begin
      errors++;
      $display("Fail %0t %s got %0d bits %h expected %0d bits %h",
               $time, name, got_n, got & mask, exp_n, exp & mask);
    end
  endtask

  task automatic check_vec(input string name, input port_vec_t got, input port_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic start_test();
    err_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%s: %s", name, (errors == err_at_start) ? "ok" : "mismatch");
  endtask

  task automatic wb_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                           output wb_dat_t rdat);
    int cnt;
    cnt = 0;
    @(posedge io);
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    wb_req.we  <= we;
    wb_req.adr <= adr;
    wb_req.dat <= wdat;
    @(negedge io);
    while (!wb_rsp.ack) begin
      cnt++;
      if (cnt > wait_limit) abort("host bus timeout, no ack");
      @(negedge io);
    end
    rdat = wb_rsp.dat;
    @(posedge io);
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
    wb_dat_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic make_payload(output logic [63:0] bits, output int len);
    bits = {$random(seed), $random(seed)};
    len  = 8 + ($unsigned($random(seed)) % 33);
  endtask

  task automatic send_packet(input port_id_t src, input port_id_t dst,
                             input logic [63:0] bits, input int len);
    int waits;
    waits = 0;
    sent_cnt[src]++;
    for (int i = 0; i < `ROUTER_PORT_W; i++) begin
      @(posedge io);
      rx.frame_n[src] <= 1'b0;
      rx.valid_n[src] <= 1'b1;
      rx.din[src]     <= dst[i];
    end
    for (int i = 0; i < `ROUTER_PAD_CYCLES; i++) begin
      @(posedge io);
      rx.din[src] <= 1'b1;
    end
    // busy_n for the grant decision shows one cycle after the last pad
    @(posedge io);
    @(negedge io);
    while (!busy_n[src]) begin
      waits++;
      if (waits > wait_limit) abort("sender timeout, busy_n stuck low");
      @(negedge io);
    end
    for (int i = 0; i < len; i++) begin
      @(posedge io);
      rx.valid_n[src] <= 1'b0;
      rx.din[src]     <= bits[i];
      rx.frame_n[src] <= (i == len - 1);
    end
    @(posedge io);
    rx.valid_n[src] <= 1'b1;
    rx.din[src]     <= 1'b1;
  endtask

  task automatic wait_packets(input int o, input int n);
    int cnt;
    cnt = 0;
    while (got_cnt[o] < n) begin
      cnt++;
      if (cnt > wait_limit) abort("timeout waiting for a packet on an output");
      @(negedge io);
    end
  endtask

  // first requester after the last granted input
  function automatic port_id_t next_grant(input port_id_t last, input port_vec_t mask);
    port_id_t idx;
    next_grant = last;
    for (int k = num_ports; k >= 1; k--) begin
      idx = last + port_id_t'(k);
      if (mask[idx]) next_grant = idx;
    end
  endfunction

  task automatic test_host_map();
    wb_dat_t d;
    start_test();
    wb_read(`ROUTER_ID_ADDR, d);
    check_word("wb_rsp.dat identity", d, `ROUTER_CHIP_ID);
    wb_read(16'h1234, d);
    check_word("wb_rsp.dat unmapped", d, '0);
    wb_write(`ROUTER_ID_ADDR, 16'hffff);
    wb_read(`ROUTER_ID_ADDR, d);
    check_word("wb_rsp.dat identity after write", d, `ROUTER_CHIP_ID);
    end_test("identity and register map");
  endtask

  task automatic test_single_route();
    logic [63:0] bits;
    int          len;
    int          base;
    start_test();
    make_payload(bits, len);
    base      = got_cnt[9];
    low_seen  = '0;
    busy_seen = '0;
    send_packet(3, 9, bits, len);
    wait_packets(9, base + 1);
    check_bits("tx.din[9]", got_bits[9][base % 8], got_len[9][base % 8], bits, len);
    check_vec("outputs with tx.frame_n low", low_seen, port_vec_t'(1) << 9);
    check_vec("inputs with busy_n low", busy_seen, '0);
    end_test("single route");
  endtask

  task automatic test_parallel_routes();
    logic [63:0] pb [4];
    int          pl [4];
    int          base [4];
    int          dst [4];
    dst = '{0, 4, 11, 14};
    start_test();
    for (int k = 0; k < 4; k++) begin
      make_payload(pb[k], pl[k]);
      base[k] = got_cnt[dst[k]];
    end
    fork
      send_packet(1, 0, pb[0], pl[0]);
      send_packet(6, 4, pb[1], pl[1]);
      send_packet(10, 11, pb[2], pl[2]);
      send_packet(13, 14, pb[3], pl[3]);
    join
    for (int k = 0; k < 4; k++) begin
      wait_packets(dst[k], base[k] + 1);
      check_bits($sformatf("tx.din[%0d]", dst[k]), got_bits[dst[k]][base[k] % 8],
                 got_len[dst[k]][base[k] % 8], pb[k], pl[k]);
    end
    end_test("parallel routes");
  endtask

  // inputs 2 and 5 race for output 7, order follows the round-robin rule
  // a lone packet from lead_src first moves the round-robin pointer
  task automatic test_contention(input string name, input int lead_src);
    logic [63:0] b2, b5, bl;
    int          l2, l5, ll;
    int          base;
    port_id_t    win;
    port_id_t    lose;
    start_test();
    if (lead_src >= 0) begin
      make_payload(bl, ll);
      base = got_cnt[7];
      send_packet(port_id_t'(lead_src), 7, bl, ll);
      wait_packets(7, base + 1);
      check_bits("tx.din[7] lead", got_bits[7][base % 8], got_len[7][base % 8], bl, ll);
      last7 = port_id_t'(lead_src);
    end
    make_payload(b2, l2);
    make_payload(b5, l5);
    base      = got_cnt[7];
    busy_seen = '0;
    win       = next_grant(last7, port_vec_t'(16'h0024));
    lose      = (win == 2) ? port_id_t'(5) : port_id_t'(2);
    fork
      send_packet(2, 7, b2, l2);
      send_packet(5, 7, b5, l5);
    join
    wait_packets(7, base + 2);
    check_bits("tx.din[7] first", got_bits[7][base % 8], got_len[7][base % 8],
               (win == 2) ? b2 : b5, (win == 2) ? l2 : l5);
    check_bits("tx.din[7] second", got_bits[7][(base + 1) % 8], got_len[7][(base + 1) % 8],
               (win == 2) ? b5 : b2, (win == 2) ? l5 : l2);
    check_vec("inputs with busy_n low", busy_seen, port_vec_t'(1) << lose);
    last7 = lose;
    end_test(name);
  endtask

  task automatic test_frame_counters();
    wb_dat_t d;
    start_test();
    for (int p = 0; p < num_ports; p++) begin
      wb_read(wb_adr_t'(`ROUTER_CNT_IN_BASE + p), d);
      check_word($sformatf("wb_rsp.dat input counter %0d", p), d, wb_dat_t'(sent_cnt[p]));
      wb_read(wb_adr_t'(`ROUTER_CNT_OUT_BASE + p), d);
      check_word($sformatf("wb_rsp.dat output counter %0d", p), d, wb_dat_t'(got_cnt[p]));
    end
    end_test("frame counters");
  endtask

  initial begin
    arst_n       = 1'b0;
    rx           = '1;
    wb_req       = '0;
    seed         = 32'hd12c_8617;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    prev_frame_n = '1;
    low_seen     = '0;
    busy_seen    = '0;
    last7        = 4'd15;
    for (int p = 0; p < num_ports; p++) begin
      sent_cnt[p] = 0;
      got_cnt[p]  = 0;
      mon_bits[p] = '0;
      mon_len[p]  = 0;
    end
    repeat (4) @(posedge io);
    arst_n <= 1'b1;
    repeat (2) @(posedge io);
    test_host_map();
    test_single_route();
    test_parallel_routes();
    test_contention("contention", -1);
    test_contention("round-robin order", 3);
    test_frame_counters();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== router.f ====
+incdir+rtl
rtl/router_pkg.sv
rtl/router_header_decoder.sv
rtl/router_output_arbiter.sv
rtl/router_crossbar.sv
rtl/router_host_regs.sv
rtl/router_top.sv
verif/router_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := router_tb
RTL_TOP   := router_top
FILELIST  := router.f
FLAGS     := --timing
BUILD     := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
